// ==== cpuStatus_golden.txt ====
# act arg data chk expected, hex. act 0 wait 1 console 2 irq 3 uba 4 cmd 5 timer-en 6 step+cmd
# chk 0 none 1 rdData 2 {cpuIRQ,piNew} 3 {cpuRUN,cpuHALT,cpuCONT} 4 rdData below expected
0 0 1 3 2
2 0 0 0 0
4 2 0 1 0
1 0 0 3 4
4 2 0 1 8
1 1 0 3 2
2 1 0 0 0
6 2 0 1 c
4 4 0 1 c
1 2 0 3 5
0 0 1 3 4
2 2 0 0 0
4 2 0 1 e
4 1 f0 0 0
4 2 0 1 0
4 1 1 0 0
4 2 0 1 1
4 1 120f0 0 0
4 2 0 1 4200
2 2 0 2 0
4 3 a0 0 0
0 0 1 2 a
4 4 0 1 2a0
3 0 a 2 a
4 3 ff 0 0
0 0 1 2 a
4 1 10020 0 0
0 0 1 2 c
4 3 f7 0 0
0 0 1 2 e
4 3 77 0 0
0 0 1 2 0
4 1 1ff0 0 0
5 0 1 0 0
4 5 5 0 0
0 0 7 0 0
4 2 0 1 101
4 6 0 4 5
5 0 0 0 0
4 1 10f0 0 0
0 0 14 0 0
4 2 0 1 100

// ==== compile.f ====
+incdir+.
ks10Pkg.sv
consoleCtrl.sv
aprFlags.sv
piArbiter.sv
intervalTimer.sv
cpuStatus.sv
cpuStatus_assert.sv
cpuStatusTb.sv

// ==== Bender.yml ====
package:
  name: ks10_cpu_status

sources:
  - include_dirs:
      - .
    files:
      - ks10Pkg.sv
      - consoleCtrl.sv
      - aprFlags.sv
      - piArbiter.sv
      - intervalTimer.sv
      - cpuStatus.sv
  - target: test
    include_dirs:
      - .
    files:
      - cpuStatus_assert.sv
      - cpuStatusTb.sv

// ==== cpuStatusTb.sv ====
/*
 * CPU status testbench
 * Replays the golden stimulus file against the KS10 CPU status block and
 * compares read-back, interrupt and console levels with the expected
 * column of each entry. Inputs change on the falling clock edge.
 */
`timescale 1ns/100ps
`include "ks10_settings.svh"

module cpuStatusTb;
   import ks10Pkg::*;

   // Golden action codes
   localparam int actWait    = 0;
   localparam int actCons    = 1;              // Arg 0 run, 1 halt, 2 cont, 3 step
   localparam int actIrq     = 2;              // Arg 0 pwr, 1 nxm, 2 cons
   localparam int actUba     = 3;
   localparam int actCmd     = 4;
   localparam int actTimerEn = 5;
   localparam int actStepCmd = 6;              // Step with a command held

   // Golden check codes
   localparam int chkNone  = 0;
   localparam int chkRead  = 1;                // rdData
   localparam int chkIrq   = 2;                // {cpuIRQ, piNew}
   localparam int chkStat  = 3;                // {cpuRUN, cpuHALT, cpuCONT}
   localparam int chkBelow = 4;                // rdData below expected

   logic                clk;
   logic                rst;
   logic                consRUN;
   logic                consHALT;
   logic                consCONT;
   logic                consSTEP;
   logic                consTIMEREN;
   logic                pwrIRQ;
   logic                nxmIRQ;
   logic                consIRQ;
   logic [1:`PI_LEVELS] ubaIRQ;
   logic                cmdValid;
   aprOp_t              cmdOp;
   word_t               cmdData;
   logic                cpuRUN;
   logic                cpuHALT;
   logic                cpuCONT;
   logic                cpuIRQ;
   logic [0:2]          piNew;
   word_t               rdData;

   // Parsed golden entries
   logic [3:0]  actQ[$];
   logic [3:0]  argQ[$];
   logic [35:0] valQ[$];
   logic [3:0]  chkQ[$];
   logic [35:0] expQ[$];
   int          nLines    = 0;
   int          nRun      = 0;
   int          nPass     = 0;
   int          nFail     = 0;
   int          setupErrs = 0;
   logic [2:0]  statSnap;                      // Console levels for chkStat

   cpuStatus dut (.*);

   initial clk = 1'b0;
   always #2 clk = ~clk;                       // 4 ns period

   ////////////////////////////////////////////////////////////////////////////
   //
   // Stimulus helpers
   //
   ////////////////////////////////////////////////////////////////////////////

   task automatic resetInputs();
      consRUN     = 1'b0;
      consHALT    = 1'b0;
      consCONT    = 1'b0;
      consSTEP    = 1'b0;
      consTIMEREN = 1'b0;
      pwrIRQ      = 1'b0;
      nxmIRQ      = 1'b0;
      consIRQ     = 1'b0;
      ubaIRQ      = '0;
      cmdValid    = 1'b0;
      cmdOp       = opNop;
      cmdData     = '0;
   endtask

   task automatic loadGolden(input int fd);
      string       txt;
      int          got;
      logic [35:0] fAct;
      logic [35:0] fArg;
      logic [35:0] fVal;
      logic [35:0] fChk;
      logic [35:0] fExp;
      while (!$feof(fd)) begin
         got = $fgets(txt, fd);
         // Comment and blank lines fail the scan
         if (got > 0 && $sscanf(txt, "%h %h %h %h %h", fAct, fArg, fVal, fChk, fExp) == 5) begin
            actQ.push_back(fAct[3:0]);
            argQ.push_back(fArg[3:0]);
            valQ.push_back(fVal);
            chkQ.push_back(fChk[3:0]);
            expQ.push_back(fExp);
         end
      end
   endtask

   task automatic startAction(input logic [3:0] act, input logic [3:0] arg,
                              input logic [35:0] val);
      case (act)
         actCons: begin
            consRUN  = (arg == 4'd0);
            consHALT = (arg == 4'd1);
            consCONT = (arg == 4'd2);
            consSTEP = (arg == 4'd3);
         end
         actIrq: begin
            pwrIRQ  = (arg == 4'd0);
            nxmIRQ  = (arg == 4'd1);
            consIRQ = (arg == 4'd2);
         end
         actUba:     ubaIRQ = val[6:0];         // Level 1 in bit 6
         actTimerEn: consTIMEREN = val[0];
         actCmd, actStepCmd: begin
            consSTEP = (act == actStepCmd);
            cmdValid = 1'b1;
            cmdOp    = aprOp_t'(arg[2:0]);
            cmdData  = val;
         end
         default: ;
      endcase
   endtask

   // Strobes and IRQ pulses last one cycle, levels stay
   task automatic endPulses(input logic keepCmd);
      consRUN  = 1'b0;
      consHALT = 1'b0;
      consCONT = 1'b0;
      consSTEP = 1'b0;
      pwrIRQ   = 1'b0;
      nxmIRQ   = 1'b0;
      consIRQ  = 1'b0;
      if (!keepCmd)
         cmdValid = 1'b0;
   endtask

   task automatic checkLine(input int entry, input logic [3:0] chk, input logic [35:0] exp);
      logic ok;
      ok = 1'b1;
      case (chk)
         chkRead: assert (rdData === exp) else begin
            $display("MISMATCH at %0t ns: entry %0d rdData %h, expected %h",
                     $time, entry, rdData, exp);
            ok = 1'b0;
         end
         chkIrq: assert ({cpuIRQ, piNew} === exp[3:0]) else begin
            $display("MISMATCH at %0t ns: entry %0d cpuIRQ/piNew %h, expected %h",
                     $time, entry, {cpuIRQ, piNew}, exp[3:0]);
            ok = 1'b0;
         end
         chkStat: assert (statSnap === exp[2:0]) else begin
            $display("MISMATCH at %0t ns: entry %0d run/halt/cont %b, expected %b",
                     $time, entry, statSnap, exp[2:0]);
            ok = 1'b0;
         end
         chkBelow: assert (rdData < exp) else begin
            $display("MISMATCH at %0t ns: entry %0d count %h, expected below %h",
                     $time, entry, rdData, exp);
            ok = 1'b0;
         end
         default: ;
      endcase
      if (chk != chkNone) begin
         nRun++;
         if (ok)
            nPass++;
         else
            nFail++;
         $display("Test %0d, golden entry %0d: %s", nRun, entry, ok ? "pass" : "FAIL");
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   //
   // Main sequence
   //
   ////////////////////////////////////////////////////////////////////////////

   initial begin : mainSeq
      int fd;
      int protoErrs;
      resetInputs();
      rst = 1'b1;
      fd = $fopen("cpuStatus_golden.txt", "r");
      if (fd == 0) begin
         $display("Could not open the golden stimulus file");
         setupErrs++;
      end else begin
         loadGolden(fd);
         $fclose(fd);
         if (actQ.size() == 0) begin
            $display("Golden file holds no stimulus entries");
            setupErrs++;
         end
      end
      nLines = actQ.size();
      repeat (3) @(negedge clk);
      rst = 1'b0;
      for (int i = 0; i < nLines; i++) begin
         startAction(actQ[i], argQ[i], valQ[i]);
         if (actQ[i] == actWait) begin
            repeat (valQ[i]) @(negedge clk);
            statSnap = {cpuRUN, cpuHALT, cpuCONT};
         end else begin
            @(negedge clk);
            statSnap = {cpuRUN, cpuHALT, cpuCONT};   // Just after the strobe clock
            endPulses(actQ[i] == actStepCmd);
            if (actQ[i] == actStepCmd) begin
               repeat (2) @(negedge clk);            // Valid spans halted, step, halted
               cmdValid = 1'b0;
            end
            @(negedge clk);                          // Write strobes land here
         end
         checkLine(i + 1, chkQ[i], expQ[i]);
      end
      protoErrs = dut.uStatusAssert.assertFails;
      $display("Summary: %0d tests, %0d passed, %0d failed, %0d assertion failures",
               nRun, nPass, nFail, protoErrs);
      if (nFail == 0 && setupErrs == 0 && protoErrs == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // 20 cycles per golden entry plus reset
   initial begin : watchdog
      wait (nLines > 0);
      repeat (20 * nLines + 3) @(posedge clk);
      $display("Run did not finish within %0d clock cycles", 20 * nLines + 3);
      $display("Something failed");
      $finish;
   end

endmodule

// ==== cpuStatus_assert.sv ====
/*
 * CPU status assertions
 * Console level and pulse rules and the PI-on gate on the CPU interrupt
 * request, bound into the top level.
 */
`timescale 1ns/100ps
`include "ks10_settings.svh"

module cpuStatusAssert (
   input logic clk,                            // Clock
   input logic rst,                            // Reset
   input logic cpuRUN,                         // Running level
   input logic cpuHALT,                        // Halted level
   input logic cpuCONT,                        // Continue pulse
   input logic cpuIRQ,                         // Interrupt to CPU
   input logic piOn                            // PI system enable
);

   int unsigned assertFails = 0;               // Failure count

   // Never running and halted at once, step has both low
   runHaltExcl: assert property (@(posedge clk) disable iff (rst) !(cpuRUN && cpuHALT))
      else begin
         assertFails++;
         $error("cpuRUN and cpuHALT high together");
      end

   contOneCycle: assert property (@(posedge clk) disable iff (rst) cpuCONT |=> !cpuCONT)
      else begin
         assertFails++;
         $error("cpuCONT held longer than one cycle");
      end

   // Request is registered one clock after the PI-on it was gated with
   irqNeedsPiOn: assert property (@(posedge clk) disable iff (rst) cpuIRQ |-> $past(piOn))
      else begin
         assertFails++;
         $error("cpuIRQ raised without PI-on");
      end

endmodule

bind cpuStatus cpuStatusAssert uStatusAssert (
   .clk(clk), .rst(rst), .cpuRUN(cpuRUN), .cpuHALT(cpuHALT), .cpuCONT(cpuCONT),
   .cpuIRQ(cpuIRQ), .piOn(piRead[`PI_ON_BIT])
);

// ==== cpuStatus.sv ====
/*
 * KS10 CPU status top
 * Console control, APR flags, priority interrupt arbiter and interval
 * timer joined by wires.
 */
`timescale 1ns/100ps
`include "ks10_settings.svh"

module cpuStatus (
   input  logic                clk,            // Clock
   input  logic                rst,            // Reset
   input  logic                consRUN,        // Console run
   input  logic                consHALT,       // Console halt
   input  logic                consCONT,       // Console continue
   input  logic                consSTEP,       // Console single step
   input  logic                consTIMEREN,    // Timer enable
   input  logic                pwrIRQ,         // Power fail pulse
   input  logic                nxmIRQ,         // NXM pulse
   input  logic                consIRQ,        // Console interrupt pulse
   input  logic [1:`PI_LEVELS] ubaIRQ,         // Unibus request levels
   input  logic                cmdValid,       // Command strobe
   input  ks10Pkg::aprOp_t     cmdOp,          // Command opcode
   input  ks10Pkg::word_t      cmdData,        // Command data
   output logic                cpuRUN,
   output logic                cpuHALT,
   output logic                cpuCONT,
   output logic                cpuIRQ,
   output logic [0:2]          piNew,
   output ks10Pkg::word_t      rdData
);
   import ks10Pkg::*;

   logic       aprWr;                          // Write strobes
   logic       piWr;
   logic       intWr;
   word_t      wrData;
   word_t      aprRead;                        // Read-back words
   word_t      piRead;
   logic [`WORD_WIDTH-`TIMER_WIDTH:`WORD_WIDTH-1] timerCount;
   logic       timerDone;                      // Interval done pulse
   logic       aprIRQ;
   logic [0:2] aprLevel;

   consoleCtrl uConsoleCtrl (
      .clk(clk), .rst(rst),
      .consRUN(consRUN), .consHALT(consHALT), .consCONT(consCONT), .consSTEP(consSTEP),
      .cmdValid(cmdValid), .cmdOp(cmdOp), .cmdData(cmdData),
      .aprRead(aprRead), .piRead(piRead), .timerCount(timerCount),
      .cpuRUN(cpuRUN), .cpuHALT(cpuHALT), .cpuCONT(cpuCONT),
      .aprWr(aprWr), .piWr(piWr), .intWr(intWr),
      .wrData(wrData), .rdData(rdData)
   );

   aprFlags uAprFlags (
      .clk(clk), .rst(rst), .aprWr(aprWr), .wrData(wrData),
      .pwrIRQ(pwrIRQ), .nxmIRQ(nxmIRQ), .consIRQ(consIRQ), .timerDone(timerDone),
      .aprIRQ(aprIRQ), .aprLevel(aprLevel), .aprRead(aprRead)
   );

   piArbiter uPiArbiter (
      .clk(clk), .rst(rst), .piWr(piWr), .wrData(wrData),
      .ubaIRQ(ubaIRQ), .aprIRQ(aprIRQ), .aprLevel(aprLevel),
      .cpuIRQ(cpuIRQ), .piNew(piNew), .piRead(piRead)
   );

   // Runs only with the console enable and the CPU running
   intervalTimer uIntervalTimer (
      .clk(clk), .rst(rst), .intWr(intWr), .wrData(wrData),
      .timerEn(consTIMEREN), .cpuRUN(cpuRUN),
      .timerDone(timerDone), .timerCount(timerCount)
   );

endmodule

// ==== intervalTimer.sv ====
/*
 * Interval timer
 * Free counter that runs while enabled and running, compared against a
 * software-loaded interval. Pulses timerDone and restarts on a match.
 */
`timescale 1ns/100ps
`include "ks10_settings.svh"

module intervalTimer (
   input  logic           clk,                 // Clock
   input  logic           rst,                 // Reset
   input  logic           intWr,               // Interval write strobe
   input  ks10Pkg::word_t wrData,              // Interval in low bits
   input  logic           timerEn,             // Console timer enable
   input  logic           cpuRUN,              // CPU running
   output logic           timerDone,           // One cycle per interval
   output logic [`WORD_WIDTH-`TIMER_WIDTH:`WORD_WIDTH-1] timerCount
);

   logic [`WORD_WIDTH-`TIMER_WIDTH:`WORD_WIDTH-1] interval;  // Match value
   logic tick;                                 // Counter advances
   logic match;                                // Interval reached

   assign tick  = timerEn && cpuRUN;
   assign match = (interval != '0) && (timerCount == interval);  // Zero never fires

   always_ff @(posedge clk) begin
      if (rst) begin
         interval   <= '0;
         timerCount <= '0;
         timerDone  <= 1'b0;
      end else begin
         timerDone <= 1'b0;
         if (intWr) begin
            interval   <= wrData[`WORD_WIDTH-`TIMER_WIDTH:`WORD_WIDTH-1];
            timerCount <= '0;                  // New interval starts clean
         end else if (tick) begin
            if (match) begin
               timerCount <= '0;
               timerDone  <= 1'b1;
            end else begin
               timerCount <= timerCount + 1'b1;
            end
         end
      end
   end

endmodule

// ==== piArbiter.sv ====
/*
 * Priority interrupt arbiter
 * PI-on bit and level enable mask, merge of the APR request into its
 * level, and the registered lowest-numbered active level with the CPU
 * interrupt request.
 */
`timescale 1ns/100ps
`include "ks10_settings.svh"

module piArbiter (
   input  logic                  clk,          // Clock
   input  logic                  rst,          // Reset
   input  logic                  piWr,         // WRPI strobe
   input  ks10Pkg::word_t        wrData,       // WRPI data
   input  logic [1:`PI_LEVELS]   ubaIRQ,       // Unibus requests, levels
   input  logic                  aprIRQ,       // APR request
   input  logic [0:2]            aprLevel,     // APR request level
   output logic                  cpuIRQ,       // Interrupt to CPU
   output logic [0:2]            piNew,        // Level being granted
   output ks10Pkg::word_t        piRead        // RDPI word
);

   logic                piOn;                  // System enable
   logic [1:`PI_LEVELS] piMask;                // Per-level enables
   logic [1:`PI_LEVELS] aprReq;                // APR request by level
   logic [1:`PI_LEVELS] activeReq;             // Requested and enabled
   logic [0:2]          newLevel;

   always_ff @(posedge clk) begin
      if (rst) begin
         piOn   <= 1'b0;
         piMask <= '0;
      end else if (piWr) begin
         piOn   <= wrData[`PI_ON_BIT];
         piMask <= wrData[`PI_MASK_LSB-`PI_LEVELS+1:`PI_MASK_LSB];
      end
   end

   // Level 0 leaves the APR unconnected
   always_comb begin
      aprReq = '0;
      for (int i = 1; i <= `PI_LEVELS; i++) begin
         if (aprIRQ && (aprLevel == 3'(i)))
            aprReq[i] = 1'b1;
      end
   end

   assign activeReq = (ubaIRQ | aprReq) & piMask & {`PI_LEVELS{piOn}};

   ////////////////////////////////////////////////////////////////////////////
   //
   // Priority encoder
   //  Level 1 is highest priority
   //
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      newLevel = 3'd0;                         // None pending
      for (int i = `PI_LEVELS; i >= 1; i--) begin
         if (activeReq[i])
            newLevel = 3'(i);                  // Lower number overrides
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         cpuIRQ <= 1'b0;
         piNew  <= 3'd0;
      end else begin
         cpuIRQ <= |activeReq;
         piNew  <= newLevel;
      end
   end

   always_comb begin
      piRead = '0;
      piRead[`PI_ON_BIT]                                = piOn;
      piRead[`PI_MASK_LSB-`PI_LEVELS+1:`PI_MASK_LSB]    = piMask;
      piRead[`PI_RDLVL_LSB-2:`PI_RDLVL_LSB]             = piNew;
   end

endmodule

// ==== aprFlags.sv ====
/*
 * APR flags
 * Power fail, NXM, console and interval-done flags with their enables
 * and the APR PI level. Raises the APR interrupt request and forms the
 * RDAPR word.
 */
`timescale 1ns/100ps
`include "ks10_settings.svh"

module aprFlags (
   input  logic           clk,                 // Clock
   input  logic           rst,                 // Reset
   input  logic           aprWr,               // WRAPR strobe
   input  ks10Pkg::word_t wrData,              // WRAPR data
   input  logic           pwrIRQ,              // Power fail pulse
   input  logic           nxmIRQ,              // NXM pulse
   input  logic           consIRQ,             // Console pulse
   input  logic           timerDone,           // Interval done pulse
   output logic           aprIRQ,              // Flag and enable both set
   output logic [0:2]     aprLevel,            // PI level of APR request
   output ks10Pkg::word_t aprRead              // RDAPR word
);

   logic [0:`APR_NFLAGS-1] flags;              // APR flags
   logic [0:`APR_NFLAGS-1] enables;            // Per-flag interrupt enables
   logic [0:`APR_NFLAGS-1] irqPulse;           // Hardware set requests
   logic [0:`APR_NFLAGS-1] flagSet;
   logic [0:`APR_NFLAGS-1] flagClr;
   logic [0:`APR_NFLAGS-1] enSet;
   logic [0:`APR_NFLAGS-1] enClr;

   always_comb begin
      irqPulse             = '0;
      irqPulse[`FLAG_PWR]  = pwrIRQ;
      irqPulse[`FLAG_NXM]  = nxmIRQ;
      irqPulse[`FLAG_CONS] = consIRQ;
      irqPulse[`FLAG_INT]  = timerDone;
   end

   // WRAPR fields, zero when no write
   assign flagSet = aprWr ? wrData[`WR_FLAGSET_LSB-`APR_NFLAGS+1:`WR_FLAGSET_LSB] : '0;
   assign flagClr = aprWr ? wrData[`WR_FLAGCLR_LSB-`APR_NFLAGS+1:`WR_FLAGCLR_LSB] : '0;
   assign enSet   = aprWr ? wrData[`WR_ENSET_LSB-`APR_NFLAGS+1:`WR_ENSET_LSB] : '0;
   assign enClr   = aprWr ? wrData[`WR_ENCLR_LSB-`APR_NFLAGS+1:`WR_ENCLR_LSB] : '0;

   ////////////////////////////////////////////////////////////////////////////
   //
   // Flag, enable and level registers
   //
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         flags    <= '0;
         enables  <= '0;
         aprLevel <= 3'd0;
      end else begin
         flags   <= ((flags & ~flagClr) | flagSet) | irqPulse;  // Pulse wins
         enables <= (enables & ~enClr) | enSet;                 // Clear, then set
         if (aprWr)
            aprLevel <= wrData[`APR_LEVEL_LSB-2:`APR_LEVEL_LSB];
      end
   end

   assign aprIRQ = |(flags & enables);

   // RDAPR word
   always_comb begin
      aprRead = '0;
      aprRead[`APR_RDFLAG_LSB-`APR_NFLAGS+1:`APR_RDFLAG_LSB] = flags;
      aprRead[`APR_RDEN_LSB-`APR_NFLAGS+1:`APR_RDEN_LSB]     = enables;
      aprRead[`APR_RDLVL_LSB-2:`APR_RDLVL_LSB]               = aprLevel;
   end

endmodule

// ==== consoleCtrl.sv ====
/*
 * Console control
 * Run/halt/continue/step state machine, command acceptance by state,
 * registered write strobes with their data, and the read-back register
 * selected by the command opcode.
 */
`timescale 1ns/100ps
`include "ks10_settings.svh"

module consoleCtrl (
   input  logic                 clk,           // Clock
   input  logic                 rst,           // Reset
   input  logic                 consRUN,       // Run
   input  logic                 consHALT,      // Halt
   input  logic                 consCONT,      // Continue
   input  logic                 consSTEP,      // Single step
   input  logic                 cmdValid,      // Command strobe
   input  ks10Pkg::aprOp_t      cmdOp,         // Command opcode
   input  ks10Pkg::word_t       cmdData,       // Command data
   input  ks10Pkg::word_t       aprRead,       // RDAPR word
   input  ks10Pkg::word_t       piRead,        // RDPI word
   input  logic [`WORD_WIDTH-`TIMER_WIDTH:`WORD_WIDTH-1] timerCount,
   output logic                 cpuRUN,        // Running level
   output logic                 cpuHALT,       // Halted level
   output logic                 cpuCONT,       // Continue pulse
   output logic                 aprWr,         // WRAPR strobe
   output logic                 piWr,          // WRPI strobe
   output logic                 intWr,         // Interval write strobe
   output ks10Pkg::word_t       wrData,        // Data for the strobes
   output ks10Pkg::word_t       rdData         // Read-back
);
   import ks10Pkg::*;

   consState_t state;                          // Console state
   consState_t nextState;
   logic       cmdAccept;                      // Command taken this cycle
   logic       cmdRead;                        // Opcode is a read
   word_t      rdSel;                          // Selected read-back

   ////////////////////////////////////////////////////////////////////////////
   //
   // Console state machine
   //
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      nextState = state;
      case (state)
         stHalted: begin
            if (consRUN || consCONT)           // Continue resumes too
               nextState = stRunning;
            else if (consSTEP)
               nextState = stStep;
         end
         stRunning: begin
            if (consHALT)
               nextState = stHalted;
         end
         stStep: nextState = stHalted;         // Single cycle only
         default: nextState = stHalted;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= stHalted;
         cpuRUN  <= 1'b0;
         cpuHALT <= 1'b1;                      // Comes up halted
         cpuCONT <= 1'b0;
      end else begin
         state   <= nextState;
         cpuRUN  <= (nextState == stRunning);  // Tracks state exactly
         cpuHALT <= (nextState == stHalted);
         cpuCONT <= consCONT && (state == stHalted);
      end
   end

   // Step and run both let commands in
   assign cmdAccept = cmdValid && ((state == stRunning) || (state == stStep));

   ////////////////////////////////////////////////////////////////////////////
   //
   // Command decode
   //
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         aprWr <= 1'b0;
         piWr  <= 1'b0;
         intWr <= 1'b0;
      end else begin
         aprWr <= cmdAccept && (cmdOp == opWrApr);
         piWr  <= cmdAccept && (cmdOp == opWrPi);
         intWr <= cmdAccept && (cmdOp == opWrInt);
      end
   end

   always_ff @(posedge clk) begin
      if (cmdAccept)
         wrData <= cmdData;                    // Lines up with the strobes
   end

   ////////////////////////////////////////////////////////////////////////////
   //
   // Read-back
   //
   ////////////////////////////////////////////////////////////////////////////

   assign cmdRead = (cmdOp == opRdApr) || (cmdOp == opRdPi) || (cmdOp == opRdTim);

   always_comb begin
      rdSel = '0;
      case (cmdOp)
         opRdApr: rdSel = aprRead;
         opRdPi:  rdSel = piRead;
         opRdTim: rdSel[`WORD_WIDTH-`TIMER_WIDTH:`WORD_WIDTH-1] = timerCount;
         default: rdSel = '0;
      endcase
   end

   // Holds until the next accepted read
   always_ff @(posedge clk) begin
      if (rst)
         rdData <= '0;
      else if (cmdAccept && cmdRead)
         rdData <= rdSel;
   end

endmodule

// ==== ks10Pkg.sv ====
/*
 * KS10 CPU status package
 * Word type, console state and command opcode encodings shared by the
 * console control, APR, PI and timer blocks.
 */
`include "ks10_settings.svh"

package ks10Pkg;

   ////////////////////////////////////////////////////////////////////////////
   //
   // Data word
   //
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [0:`WORD_WIDTH-1] word_t;    // Bit 0 is MSB

   ////////////////////////////////////////////////////////////////////////////
   //
   // Console state
   //
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      stHalted  = 2'd0,                        // Stopped, commands ignored
      stRunning = 2'd1,                        // Free running
      stStep    = 2'd2                         // One cycle, then back to halt
   } consState_t;

   ////////////////////////////////////////////////////////////////////////////
   //
   // Command port opcodes
   //  Stand-ins for the APR/PI/timer microinstructions
   //
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      opNop   = 3'd0,                          // Accepted, no effect
      opWrApr = 3'd1,                          // Flag/enable fields and APR level
      opRdApr = 3'd2,                          // Flags, enables, level
      opWrPi  = 3'd3,                          // PI-on and level mask
      opRdPi  = 3'd4,                          // PI-on, mask, current level
      opWrInt = 3'd5,                          // Interval from low 18 bits
      opRdTim = 3'd6                           // Running count
   } aprOp_t;

   // Code 7 unused

endpackage

// ==== ks10_settings.svh ====
/*
 * KS10 CPU status settings
 * Word widths, APR flag positions, WRAPR/WRPI field positions and the
 * interval timer width. Bit 0 is the MSB of a 36-bit word, so the low
 * end of a field is its rightmost, highest-numbered bit.
 */
`ifndef KS10_SETTINGS_SVH
`define KS10_SETTINGS_SVH

// Word sizes
`define WORD_WIDTH      36               // KS10 data word
`define TIMER_WIDTH     18               // Interval and count registers

// APR flags, index into the flag vector
`define APR_NFLAGS      4
`define FLAG_PWR        0                // Power fail, read bit 32
`define FLAG_NXM        1                // Non-existent memory, read bit 33
`define FLAG_CONS       2                // Console, read bit 34
`define FLAG_INT        3                // Interval done, read bit 35

// RDAPR word layout
`define APR_RDFLAG_LSB  35               // Flags in 32..35
`define APR_RDEN_LSB    27               // Enables in 24..27
`define APR_RDLVL_LSB   22               // PI level in 20..22

// WRAPR fields, 4 bits each, low end given
`define WR_FLAGSET_LSB  35               // Set flags 32..35
`define WR_FLAGCLR_LSB  31               // Clear flags 28..31
`define WR_ENCLR_LSB    27               // Clear enables 24..27
`define WR_ENSET_LSB    23               // Set enables 20..23
`define APR_LEVEL_LSB   20               // Level in 18..20, shares bit 20 with enable set

// Priority interrupt
`define PI_LEVELS       7                // Levels 1 to 7, 0 is none
`define PI_ON_BIT       28               // WRPI/RDPI PI-on
`define PI_MASK_LSB     35               // Level enables in 29..35
`define PI_RDLVL_LSB    27               // Current level in 25..27 on RDPI

`endif
